/* Bender.yml */
package:
  name: rob

sources:
  - rob_pkg.sv
  - rob_ctrl.sv
  - rob_entries.sv
  - rob_operand_fwd.sv
  - reg_map.sv
  - rob_top.sv
  - target: test
    files:
      - rob_assert.sv
      - tb_rob.sv

/* flist.f */
rob_pkg.sv
rob_ctrl.sv
rob_entries.sv
rob_operand_fwd.sv
reg_map.sv
rob_top.sv
rob_assert.sv
tb_rob.sv

/* reg_map.sv */
// ==================================================
// Architectural register map with value, busy bit
// and rename tag per register
// ==================================================
module reg_map (
    input  logic                            clk,
    input  logic                            n_rst,
    input  logic [1:0][rob_pkg::REG_W-1:0]  rsrc,
    output rob_pkg::operand_t [1:0]         map_src,
    input  logic                            tag_we,
    input  logic [rob_pkg::REG_W-1:0]       tag_rdest,
    input  logic [rob_pkg::TAG_W-1:0]       tag,
    input  rob_pkg::commit_t                commit,
    input  logic [rob_pkg::TAG_W-1:0]       commit_tag,
    input  logic                            flush
);
    import rob_pkg::*;

    logic [DATA_W-1:0]   value [NUM_REGS];
    logic [TAG_W-1:0]    rtag  [NUM_REGS];
    logic [NUM_REGS-1:0] busy;
    logic                clear_busy;

    // Only the youngest producer of a register may release it
    // Any retiring op with a matching tag releases it so that stores and
    // branches never leave a register busy behind them
    assign clear_busy = commit.en && (rtag[commit.rdest] == commit_tag);

    // Retired values land here, including the one retiring with a redirect
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                value[r] <= '0;
            end
        end else if (commit.wr) begin
            value[commit.rdest] <= commit.data;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            busy <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                rtag[r] <= '0;
            end
        end else if (flush) begin
            // Nothing is in flight after a redirect
            busy <= '0;
        end else begin
            if (clear_busy) begin
                busy[commit.rdest] <= 1'b0;
            end
            // A new rename overrides the clear when both hit one register
            if (tag_we) begin
                busy[tag_rdest] <= 1'b1;
                rtag[tag_rdest] <= tag;
            end
        end
    end

    // Lookups see the state before this cycle's own rename
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            map_src[i].rdy  = !busy[rsrc[i]];
            map_src[i].tag  = rtag[rsrc[i]];
            map_src[i].data = value[rsrc[i]];
        end
    end

endmodule

/* rob_assert.sv */
// ==================================================
// Concurrent protocol assertions for the ROB top
// level and their bind into rob_top
// ==================================================
module rob_assert #(
    parameter int ROB_DEPTH = 8
) (
    input logic                         clk,
    input logic                         n_rst,
    input logic                         dispatch_en,
    input logic                         stall,
    input logic [rob_pkg::TAG_W-1:0]    tag,
    input logic [rob_pkg::TAG_W-1:0]    head_idx,
    input rob_pkg::commit_t             commit,
    input logic                         redirect
);
    import rob_pkg::*;

    logic empty;

    // Tail and head on the same slot without a full buffer means nothing is in flight
    assign empty = (tag == head_idx) && !stall;

    a_no_commit_empty: assert property (@(posedge clk) disable iff (!n_rst)
        empty |-> !commit.en)
        else $error("commit while the ROB is empty");

    a_redirect_commit: assert property (@(posedge clk) disable iff (!n_rst)
        redirect |-> commit.en)
        else $error("redirect without a commit");

    // A held dispatch cannot get in until an entry leaves
    a_stall_held: assert property (@(posedge clk) disable iff (!n_rst)
        (stall && dispatch_en && !commit.en) |=> stall)
        else $error("stall dropped with no commit");

    a_tag_step: assert property (@(posedge clk) disable iff (!n_rst)
        (dispatch_en && !stall && !redirect) |=>
        (tag == TAG_W'(($past(tag) + 1) % ROB_DEPTH)))
        else $error("tag did not advance by one on a dispatch");

endmodule

bind rob_top rob_assert #(
    .ROB_DEPTH      (ROB_DEPTH)
) u_rob_assert (
    .clk            (clk),
    .n_rst          (n_rst),
    .dispatch_en    (dispatch.en),
    .stall          (stall),
    .tag            (tag),
    .head_idx       (head_idx),
    .commit         (commit),
    .redirect       (redirect)
);

/* rob_ctrl.sv */
// ==================================================
// ROB control with head and tail pointers, full and
// empty detection, retire and redirect decisions
// ==================================================
module rob_ctrl #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        dispatch_en,
    input  rob_pkg::rob_entry_t         head_entry,
    output logic                        stall,
    output logic                        dispatch_we,
    output logic [rob_pkg::TAG_W-1:0]   tail_idx,
    output logic [rob_pkg::TAG_W-1:0]   head_idx,
    output rob_pkg::commit_t            commit,
    output logic                        flush,
    output logic                        redirect,
    output logic [rob_pkg::ADDR_W-1:0]  redirect_addr
);
    import rob_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    // Pointers carry one extra wrap bit so full and empty can be told apart
    logic [IDX_W:0] head_ptr;
    logic [IDX_W:0] tail_ptr;
    logic           full;
    logic           empty;
    logic           retire;

    assign empty = (tail_ptr == head_ptr);
    // Same slot but opposite wrap bits means the tail has lapped the head
    assign full  = (tail_ptr[IDX_W] != head_ptr[IDX_W]) &&
                   (tail_ptr[IDX_W-1:0] == head_ptr[IDX_W-1:0]);

    assign stall       = full;
    assign dispatch_we = dispatch_en && !full;

    // Tags are the slot index zero extended to the fixed tag width
    assign tail_idx = TAG_W'(tail_ptr[IDX_W-1:0]);
    assign head_idx = TAG_W'(head_ptr[IDX_W-1:0]);

    // The head retires as soon as its result is known
    assign retire = head_entry.rdy && !empty;

    always_comb begin
        commit.en    = retire;
        commit.wr    = retire && op_writes_reg(head_entry.op);
        commit.rdest = head_entry.rdest;
        commit.data  = head_entry.data;
    end

    // A retiring redirect sends fetch to the new address and drops all younger work
    assign redirect      = retire && head_entry.redirect;
    assign redirect_addr = head_entry.addr;
    assign flush         = redirect;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            tail_ptr <= '0;
        end else if (flush) begin
            tail_ptr <= '0;
        end else if (dispatch_we) begin
            tail_ptr <= tail_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head_ptr <= '0;
        end else if (flush) begin
            head_ptr <= '0;
        end else if (retire) begin
            head_ptr <= head_ptr + 1'b1;
        end
    end

endmodule

/* rob_entries.sv */
// ==================================================
// ROB entry storage with dispatch and CDB write
// ports, a head read port and two lookup ports
// ==================================================
module rob_entries #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                            clk,
    input  rob_pkg::dispatch_t              dispatch,
    input  logic                            dispatch_we,
    input  logic [rob_pkg::TAG_W-1:0]       tail_idx,
    input  rob_pkg::cdb_t                   cdb,
    input  logic [rob_pkg::TAG_W-1:0]       head_idx,
    output rob_pkg::rob_entry_t             head_entry,
    input  logic [1:0][rob_pkg::TAG_W-1:0]  look_tag,
    output rob_pkg::rob_entry_t [1:0]       look_entry
);
    import rob_pkg::*;

    localparam int IDX_W = $clog2(ROB_DEPTH);

    rob_entry_t entries [ROB_DEPTH];

    logic [IDX_W-1:0] wr_slot;
    logic [IDX_W-1:0] cdb_slot;

    // Only the low tag bits select a slot when the ROB is shallower than 16
    assign wr_slot  = tail_idx[IDX_W-1:0];
    assign cdb_slot = cdb.tag[IDX_W-1:0];

    // Dispatch writes a whole entry while the CDB fills in the result fields
    // of an older one, so a completion is never lost to a same-cycle dispatch
    always_ff @(posedge clk) begin
        if (dispatch_we) begin
            entries[wr_slot].rdy      <= dispatch.rdy;
            entries[wr_slot].redirect <= 1'b0;
            entries[wr_slot].op       <= dispatch.op;
            entries[wr_slot].iaddr    <= dispatch.iaddr;
            entries[wr_slot].addr     <= dispatch.addr;
            entries[wr_slot].data     <= dispatch.data;
            entries[wr_slot].rdest    <= dispatch.rdest;
        end
        if (cdb.en) begin
            entries[cdb_slot].rdy      <= 1'b1;
            entries[cdb_slot].redirect <= cdb.redirect;
            entries[cdb_slot].data     <= cdb.data;
            entries[cdb_slot].addr     <= cdb.addr;
        end
    end

    // Oldest entry for the retire decision
    assign head_entry = entries[head_idx[IDX_W-1:0]];

    // Producer entries named by the register map for the two sources
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            look_entry[i] = entries[look_tag[i][IDX_W-1:0]];
        end
    end

endmodule

/* rob_operand_fwd.sv */
// ==================================================
// Source operand resolution from register map, CDB
// bypass or ROB entry
// ==================================================
module rob_operand_fwd (
    input  rob_pkg::cdb_t                   cdb,
    input  rob_pkg::operand_t [1:0]         map_src,
    input  rob_pkg::rob_entry_t [1:0]       look_entry,
    output logic [1:0][rob_pkg::TAG_W-1:0]  look_tag,
    output rob_pkg::operand_t [1:0]         src
);
    import rob_pkg::*;

    logic [1:0] cdb_hit;

    // A broadcast this cycle that matches the producer tag of a source
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cdb_hit[i] = cdb.en && (cdb.tag == map_src[i].tag);
        end
    end

    // Storage is always looked up with the tag held in the register map
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            look_tag[i] = map_src[i].tag;
        end
    end

    // Committed register data has first say
    // Otherwise a same-cycle CDB result beats the stored entry, because the
    // entry only picks up that result at the end of this cycle
    // Otherwise the producer entry supplies its data and tells whether it is ready
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (map_src[i].rdy) begin
                src[i] = map_src[i];
            end else if (cdb_hit[i]) begin
                src[i].rdy  = 1'b1;
                src[i].tag  = cdb.tag;
                src[i].data = cdb.data;
            end else begin
                src[i].rdy  = look_entry[i].rdy;
                src[i].tag  = map_src[i].tag;
                src[i].data = look_entry[i].data;
            end
        end
    end

endmodule

/* rob_pkg.sv */
// ==================================================
// Shared widths, opcode enum and packed structs for
// the re-order buffer and register map
// ==================================================
package rob_pkg;

    // Operand, address, register index and tag widths
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 1 << REG_W;
    // Sized for the deepest ROB of 16 entries and smaller depths use the low bits
    localparam int TAG_W    = 4;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } rob_op_t;

    // New instruction from the dispatcher
    typedef struct packed {
        logic                   en;
        rob_op_t                op;
        logic [REG_W-1:0]       rdest;
        logic [1:0][REG_W-1:0]  rsrc;
        logic [ADDR_W-1:0]      iaddr;
        logic [ADDR_W-1:0]      addr;
        logic [DATA_W-1:0]      data;
        // Result is already known when the instruction is dispatched
        logic                   rdy;
    } dispatch_t;

    // Result broadcast from an execution unit
    typedef struct packed {
        logic                   en;
        logic [TAG_W-1:0]       tag;
        logic [DATA_W-1:0]      data;
        logic [ADDR_W-1:0]      addr;
        logic                   redirect;
    } cdb_t;

    // Resolved source operand
    typedef struct packed {
        logic                   rdy;
        logic [TAG_W-1:0]       tag;
        logic [DATA_W-1:0]      data;
    } operand_t;

    // Retirement into the architectural register map
    typedef struct packed {
        logic                   en;
        logic                   wr;
        logic [REG_W-1:0]       rdest;
        logic [DATA_W-1:0]      data;
    } commit_t;

    // One stored ROB entry
    typedef struct packed {
        logic                   rdy;
        logic                   redirect;
        rob_op_t                op;
        logic [ADDR_W-1:0]      iaddr;
        logic [ADDR_W-1:0]      addr;
        logic [DATA_W-1:0]      data;
        logic [REG_W-1:0]       rdest;
    } rob_entry_t;

    // Only ALU and load results go to a register
    function automatic logic op_writes_reg(rob_op_t op);
        return (op == OP_ALU) || (op == OP_LOAD);
    endfunction

endpackage

/* rob_top.sv */
// ==================================================
// ROB subsystem top level joining control, entry
// storage, operand forwarding and register map
// ==================================================
module rob_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        n_rst,
    input  rob_pkg::dispatch_t          dispatch,
    input  rob_pkg::cdb_t               cdb,
    output logic                        stall,
    output logic [rob_pkg::TAG_W-1:0]   tag,
    output rob_pkg::operand_t [1:0]     src,
    output rob_pkg::commit_t            commit,
    output logic                        redirect,
    output logic [rob_pkg::ADDR_W-1:0]  redirect_addr
);
    import rob_pkg::*;

    logic                   dispatch_we;
    logic [TAG_W-1:0]       head_idx;
    logic                   flush;
    rob_entry_t             head_entry;
    logic [1:0][TAG_W-1:0]  look_tag;
    rob_entry_t [1:0]       look_entry;
    operand_t [1:0]         map_src;

    // The tail index doubles as the tag handed to the next dispatch
    rob_ctrl #(
        .ROB_DEPTH      (ROB_DEPTH)
    ) u_rob_ctrl (
        .clk            (clk),
        .n_rst          (n_rst),
        .dispatch_en    (dispatch.en),
        .head_entry     (head_entry),
        .stall          (stall),
        .dispatch_we    (dispatch_we),
        .tail_idx       (tag),
        .head_idx       (head_idx),
        .commit         (commit),
        .flush          (flush),
        .redirect       (redirect),
        .redirect_addr  (redirect_addr)
    );

    rob_entries #(
        .ROB_DEPTH      (ROB_DEPTH)
    ) u_rob_entries (
        .clk            (clk),
        .dispatch       (dispatch),
        .dispatch_we    (dispatch_we),
        .tail_idx       (tag),
        .cdb            (cdb),
        .head_idx       (head_idx),
        .head_entry     (head_entry),
        .look_tag       (look_tag),
        .look_entry     (look_entry)
    );

    rob_operand_fwd u_rob_operand_fwd (
        .cdb            (cdb),
        .map_src        (map_src),
        .look_entry     (look_entry),
        .look_tag       (look_tag),
        .src            (src)
    );

    // Renames follow accepted dispatches and releases follow retirement
    reg_map u_reg_map (
        .clk            (clk),
        .n_rst          (n_rst),
        .rsrc           (dispatch.rsrc),
        .map_src        (map_src),
        .tag_we         (dispatch_we),
        .tag_rdest      (dispatch.rdest),
        .tag            (tag),
        .commit         (commit),
        .commit_tag     (head_idx),
        .flush          (flush)
    );

endmodule

/* tb_rob.sv */
// ==================================================
// Testbench for rob_top with a reference model of
// the ROB queue and register map, and a watchdog
// ==================================================
module tb_rob;
    import rob_pkg::*;

    localparam int ROB_DEPTH = 8;

    typedef struct packed {
        logic               rdy;
        logic               redirect;
        rob_op_t            op;
        logic [REG_W-1:0]   rdest;
        logic [TAG_W-1:0]   tag;
        logic [DATA_W-1:0]  data;
        logic [ADDR_W-1:0]  addr;
    } model_entry_t;

    logic               clk = 1'b0;
    logic               n_rst;
    dispatch_t          dispatch;
    cdb_t               cdb;
    logic               stall;
    logic [TAG_W-1:0]   tag;
    operand_t [1:0]     src;
    commit_t            commit;
    logic               redirect;
    logic [ADDR_W-1:0]  redirect_addr;

    // Reference state kept by the same rules as the register map
    model_entry_t       m_q[$];
    logic [DATA_W-1:0]  m_val  [NUM_REGS];
    logic [TAG_W-1:0]   m_rtag [NUM_REGS];
    logic               m_busy [NUM_REGS];
    int                 m_tail = 0;

    integer seed = 23980;
    int     issued = 0;
    int     cycles = 0;
    int     fail_count = 0;
    string  test_name = "reset";

    rob_top #(
        .ROB_DEPTH      (ROB_DEPTH)
    ) u_rob_top (
        .clk            (clk),
        .n_rst          (n_rst),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .stall          (stall),
        .tag            (tag),
        .src            (src),
        .commit         (commit),
        .redirect       (redirect),
        .redirect_addr  (redirect_addr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            fail_count++;
            $display("MISMATCH %s %s: expected %0h actual %0h", test_name, what, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    // Outputs are compared mid-cycle, then the model steps to the coming edge
    always @(negedge clk) begin : model_check
        model_entry_t       head;
        logic               exp_en;
        logic               exp_full;
        logic               exp_rdy;
        logic [DATA_W-1:0]  exp_data;
        logic [REG_W-1:0]   r;
        if (n_rst) begin
            exp_en   = (m_q.size() > 0) && m_q[0].rdy;
            exp_full = (m_q.size() == ROB_DEPTH);
            check_val("commit.en", exp_en, commit.en);
            check_val("stall", exp_full, stall);
            check_val("tag", m_tail, tag);
            if (exp_en) begin
                head = m_q[0];
                check_val("commit.wr", (head.op == OP_ALU) || (head.op == OP_LOAD), commit.wr);
                check_val("commit.rdest", head.rdest, commit.rdest);
                check_val("commit.data", head.data, commit.data);
                check_val("redirect", head.redirect, redirect);
                if (head.redirect) begin
                    check_val("redirect_addr", head.addr, redirect_addr);
                end
            end else begin
                check_val("redirect", 1'b0, redirect);
            end
            // Ready map data first, then a same-cycle CDB result, then the producer entry
            for (int i = 0; i < 2; i++) begin
                r        = dispatch.rsrc[i];
                exp_rdy  = 1'b1;
                exp_data = m_val[r];
                if (m_busy[r]) begin
                    if (cdb.en && (cdb.tag == m_rtag[r])) begin
                        exp_data = cdb.data;
                    end else begin
                        exp_rdy = 1'b0;
                        foreach (m_q[j]) begin
                            if (m_q[j].tag == m_rtag[r]) begin
                                exp_rdy  = m_q[j].rdy;
                                exp_data = m_q[j].data;
                            end
                        end
                    end
                end
                check_val($sformatf("src%0d.rdy", i), exp_rdy, src[i].rdy);
                check_val($sformatf("src%0d.tag", i), m_rtag[r], src[i].tag);
                if (exp_rdy) begin
                    check_val($sformatf("src%0d.data", i), exp_data, src[i].data);
                end
            end
            if (cdb.en) begin
                foreach (m_q[j]) begin
                    if (m_q[j].tag == cdb.tag) begin
                        m_q[j].rdy      = 1'b1;
                        m_q[j].data     = cdb.data;
                        m_q[j].addr     = cdb.addr;
                        m_q[j].redirect = cdb.redirect;
                    end
                end
            end
            if (exp_en) begin
                head = m_q.pop_front();
                if ((head.op == OP_ALU) || (head.op == OP_LOAD)) begin
                    m_val[head.rdest] = head.data;
                end
                if (m_rtag[head.rdest] == head.tag) begin
                    m_busy[head.rdest] = 1'b0;
                end
            end
            if (exp_en && head.redirect) begin
                // Everything younger is dropped and renaming starts over at slot zero
                m_q.delete();
                m_tail = 0;
                foreach (m_busy[k]) m_busy[k] = 1'b0;
            end else if (dispatch.en && !exp_full) begin
                m_q.push_back('{dispatch.rdy, 1'b0, dispatch.op, dispatch.rdest,
                                TAG_W'(m_tail), dispatch.data, dispatch.addr});
                m_busy[dispatch.rdest] = 1'b1;
                m_rtag[dispatch.rdest] = TAG_W'(m_tail);
                m_tail = (m_tail + 1) % ROB_DEPTH;
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic send(input rob_op_t op, input logic [REG_W-1:0] rdest, input logic rdy);
        dispatch.en      = 1'b1;
        dispatch.op      = op;
        dispatch.rdest   = rdest;
        dispatch.rsrc[0] = REG_W'(rand32());
        dispatch.rsrc[1] = REG_W'(rand32());
        dispatch.iaddr   = rand32();
        dispatch.addr    = rand32();
        dispatch.data    = rand32();
        dispatch.rdy     = rdy;
        issued++;
        tick();
        dispatch.en = 1'b0;
    endtask

    task automatic complete(input logic [TAG_W-1:0] t, input logic redir);
        cdb.en       = 1'b1;
        cdb.tag      = t;
        cdb.data     = rand32();
        cdb.addr     = rand32();
        cdb.redirect = redir;
        tick();
        cdb.en = 1'b0;
    endtask

    // Completes every pending entry in random tag order and waits until all retire
    task automatic drain();
        logic [TAG_W-1:0] pend[$];
        int               pick;
        foreach (m_q[j]) begin
            if (!m_q[j].rdy) pend.push_back(m_q[j].tag);
        end
        while (pend.size() > 0) begin
            pick = rand32() % pend.size();
            complete(pend[pick], 1'b0);
            pend.delete(pick);
        end
        while (m_q.size() != 0) tick();
    endtask

    initial begin : watchdog
        while (cycles <= 20 * issued + 200) @(posedge clk);
        $display("Timeout after %0d cycles with %0d instructions issued", cycles, issued);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        logic [TAG_W-1:0] tag_a;
        logic [TAG_W-1:0] tag_b;
        logic [TAG_W-1:0] tag_c;
        int               n;
        dispatch = '0;
        cdb      = '0;
        n_rst    = 1'b0;
        foreach (m_val[k]) begin
            m_val[k]  = '0;
            m_rtag[k] = '0;
            m_busy[k] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        n_rst = 1'b1;
        // Idle cycles with random source indices read the cleared register file
        repeat (4) begin
            dispatch.rsrc[0] = REG_W'(rand32());
            dispatch.rsrc[1] = REG_W'(rand32());
            tick();
        end
        test_name = "in_order";
        repeat (4) begin
            n = (rand32() % ROB_DEPTH) + 1;
            repeat (n) send(rob_op_t'(2'(rand32())), REG_W'(rand32()), 1'b0);
            drain();
        end
        test_name = "full";
        repeat (ROB_DEPTH) send(OP_ALU, REG_W'(rand32()), 1'b0);
        // Ninth dispatch is held against the full buffer
        dispatch.en = 1'b1;
        issued++;
        repeat (3) tick();
        complete(m_q[0].tag, 1'b0);
        repeat (3) tick();
        dispatch.en = 1'b0;
        drain();
        test_name = "operands";
        tag_a = TAG_W'(m_tail);
        send(OP_ALU, 5'd1, 1'b0);
        tag_b = TAG_W'(m_tail);
        send(OP_ALU, 5'd2, 1'b0);
        tag_c = TAG_W'(m_tail);
        send(OP_LOAD, 5'd3, 1'b0);
        complete(tag_b, 1'b0);
        // r2 comes from its completed entry and r5 straight from the map
        dispatch.rsrc[0] = 5'd2;
        dispatch.rsrc[1] = 5'd5;
        tick();
        // r1 is still pending while r3 is bypassed from this cycle's CDB pulse
        dispatch.rsrc[0] = 5'd1;
        dispatch.rsrc[1] = 5'd3;
        complete(tag_c, 1'b0);
        complete(tag_a, 1'b0);
        while (m_q.size() != 0) tick();
        test_name = "redirect";
        tag_a = TAG_W'(m_tail);
        send(OP_ALU, 5'd4, 1'b0);
        tag_b = TAG_W'(m_tail);
        send(OP_BRANCH, 5'd6, 1'b0);
        send(OP_ALU, 5'd7, 1'b0);
        send(OP_LOAD, 5'd8, 1'b1);
        complete(tag_b, 1'b1);
        complete(tag_a, 1'b0);
        while (m_q.size() != 0) tick();
        // r7 and r8 were renamed by flushed ops and only the flush frees them
        dispatch.rsrc[0] = 5'd7;
        dispatch.rsrc[1] = 5'd8;
        tick();
        dispatch.rsrc[0] = 5'd6;
        dispatch.rsrc[1] = 5'd4;
        tick();
        repeat (4) begin
            dispatch.rsrc[0] = REG_W'(rand32());
            dispatch.rsrc[1] = REG_W'(rand32());
            tick();
        end
        if (fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "checks failed");
        end
    end

endmodule
